//--- build.f
hdl/decoder_pkg.sv
hdl/processing_unit.sv
hdl/neighbor_link.sv
hdl/cluster_parity.sv
hdl/decoding_graph.sv
verif/decoding_graph_checker.sv
verif/decoding_graph_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module decoding_graph_tb -f build.f -o decoding_graph_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/decoding_graph_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- verif/decoding_graph_tb.sv
module decoding_graph_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int ENTRY_COUNT = 6;
    localparam int MAX_ITERATIONS = 6;
    // Two loads per entry, then per iteration a grow, the merge edges and an idle edge
    localparam int WATCHDOG_TIME = CLK_PERIOD * (RESET_CYCLES + 4
        + ENTRY_COUNT * (4 + MAX_ITERATIONS * (3 + decoder_pkg::PU_COUNT)));

    typedef struct packed {
        logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0] round0;
        logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0] round1;
        logic [3:0] iteration_limit;
    } stimulus_t;

    logic clk;
    logic rst_n;
    logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0] measurements;
    decoder_pkg::stage_t stage;
    logic [decoder_pkg::PU_COUNT-1:0] odd_clusters;
    decoder_pkg::pu_address_t [decoder_pkg::PU_COUNT-1:0] roots;
    logic [decoder_pkg::PU_COUNT-1:0] busy;
    int error_count;
    int check_count;
    int failures;
    logic [31:0] lcg_state;
    stimulus_t stimulus_table [ENTRY_COUNT];

    decoding_graph decoding_graph_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .measurements_i (measurements),
        .global_stage_i (stage),
        .odd_clusters_o (odd_clusters),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    decoding_graph_checker checker_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .measurements_i (measurements),
        .global_stage_i (stage),
        .odd_clusters_i (odd_clusters),
        .roots_i        (roots),
        .busy_i         (busy),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fill_table();
        stimulus_table[0] = '{round0: 9'b000_011_000, round1: 9'b0, iteration_limit: 4'd4};
        stimulus_table[1] = '{round0: 9'b000_000_001, round1: 9'b0, iteration_limit: 4'd4};
        stimulus_table[2] = '{round0: 9'b000_010_000, round1: 9'b000_010_000,
                              iteration_limit: 4'd4}; // Vertical pair
        stimulus_table[3] = '{round0: 9'b000_000_010, round1: 9'b100_000_000,
                              iteration_limit: 4'd5};
        lcg_state = 32'd5;
        for (int e = 4; e < ENTRY_COUNT; e++) begin
            lcg_state = lcg_next(lcg_state);
            stimulus_table[e].round0 = lcg_state[24:16]; // Upper bits mix better
            lcg_state = lcg_next(lcg_state);
            stimulus_table[e].round1 = lcg_state[24:16];
            stimulus_table[e].iteration_limit = 4'(MAX_ITERATIONS);
        end
    endtask

    task automatic load_word(input logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0] word);
        @(posedge clk);
        measurements <= word;
        stage <= decoder_pkg::STAGE_LOADING;
    endtask

    task automatic run_entry(input stimulus_t s, input int index);
        int iteration;
        int merge_edges;
        load_word(s.round0);
        load_word(s.round1);
        @(posedge clk);
        stage <= decoder_pkg::STAGE_IDLE;
        measurements <= '0;
        @(negedge clk);
        iteration = 0;
        while (odd_clusters != '0 && iteration < int'(s.iteration_limit)) begin
            @(posedge clk);
            stage <= decoder_pkg::STAGE_GROW;
            @(posedge clk);
            stage <= decoder_pkg::STAGE_MERGE;
            @(negedge clk);
            merge_edges = 0;
            while (busy != '0 && merge_edges < decoder_pkg::PU_COUNT) begin
                @(posedge clk);
                merge_edges++;
                @(negedge clk);
            end
            if (busy != '0) begin
                failures++;
                $display("Merge of entry %0d did not settle within %0d edges", index, merge_edges);
            end
            @(posedge clk);
            stage <= decoder_pkg::STAGE_IDLE;
            @(negedge clk);
            iteration++;
        end
        if (odd_clusters != '0) begin
            failures++;
            $display("Decoding of entry %0d did not finish within %0d iterations",
                index, s.iteration_limit);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units before the tests ended", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        stage = decoder_pkg::STAGE_IDLE;
        measurements = '0;
        failures = 0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int e = 0; e < ENTRY_COUNT; e++) begin
            run_entry(stimulus_table[e], e);
        end
        @(posedge clk);
        @(negedge clk);
        $display("Closing report: %0d checks, %0d mismatches, %0d sequencing failures",
            check_count, error_count, failures);
        if (error_count == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verif/decoding_graph_checker.sv
module decoding_graph_checker (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0]           measurements_i,
    input  decoder_pkg::stage_t                                  global_stage_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                     odd_clusters_i,
    input  decoder_pkg::pu_address_t [decoder_pkg::PU_COUNT-1:0] roots_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                     busy_i,
    output int                                                   error_count_o,
    output int                                                   check_count_o
);

    // Reference state, one entry per unit
    logic m_defect [decoder_pkg::PU_COUNT];
    decoder_pkg::pu_address_t m_root [decoder_pkg::PU_COUNT];
    logic m_touched [decoder_pkg::PU_COUNT];
    logic [decoder_pkg::LINK_BITS-1:0] m_count [decoder_pkg::PU_COUNT][decoder_pkg::NEIGHBOR_COUNT];

    decoder_pkg::pu_address_t next_root [decoder_pkg::PU_COUNT];
    logic next_touched [decoder_pkg::PU_COUNT];
    logic [decoder_pkg::PU_COUNT-1:0] odd_now;
    logic [decoder_pkg::PU_COUNT-1:0] odd_expected;
    logic [decoder_pkg::PU_COUNT-1:0] busy_expected;
    int errors = 0;
    int checks = 0;

    function automatic int unit_u(input int i);
        return i / decoder_pkg::PU_COUNT_PER_ROUND;
    endfunction

    function automatic int unit_x(input int i);
        return (i % decoder_pkg::PU_COUNT_PER_ROUND) / decoder_pkg::GRID_Z;
    endfunction

    function automatic int unit_z(input int i);
        return i % decoder_pkg::GRID_Z;
    endfunction

    function automatic decoder_pkg::pu_address_t own_address(input int i);
        decoder_pkg::pu_address_t a;
        int u;
        int x;
        int z;
        u = unit_u(i);
        x = unit_x(i);
        z = unit_z(i);
        a.u = u[decoder_pkg::U_BITS-1:0];
        a.x = x[decoder_pkg::X_BITS-1:0];
        a.z = z[decoder_pkg::Z_BITS-1:0];
        return a;
    endfunction

    function automatic int address_index(input decoder_pkg::pu_address_t a);
        return int'(a.u) * decoder_pkg::PU_COUNT_PER_ROUND + int'(a.x) * decoder_pkg::GRID_Z
            + int'(a.z);
    endfunction

    // Internal neighbor across a direction, -1 at the grid edge
    function automatic int neighbor_of(input int i, input int d);
        if (d == decoder_pkg::DIR_NORTH && unit_x(i) > 0) return i - decoder_pkg::GRID_Z;
        if (d == decoder_pkg::DIR_SOUTH && unit_x(i) < decoder_pkg::GRID_X - 1)
            return i + decoder_pkg::GRID_Z;
        if (d == decoder_pkg::DIR_WEST && unit_z(i) > 0) return i - 1;
        if (d == decoder_pkg::DIR_EAST && unit_z(i) < decoder_pkg::GRID_Z - 1) return i + 1;
        if (d == decoder_pkg::DIR_DOWN && unit_u(i) > 0)
            return i - decoder_pkg::PU_COUNT_PER_ROUND;
        if (d == decoder_pkg::DIR_UP && unit_u(i) < decoder_pkg::GRID_U - 1)
            return i + decoder_pkg::PU_COUNT_PER_ROUND;
        return -1;
    endfunction

    function automatic logic at_boundary(input int i, input int d);
        return (d == decoder_pkg::DIR_WEST && unit_z(i) == 0)
            || (d == decoder_pkg::DIR_EAST && unit_z(i) == decoder_pkg::GRID_Z - 1)
            || (d == decoder_pkg::DIR_DOWN && unit_u(i) == 0);
    endfunction

    function automatic logic [decoder_pkg::LINK_BITS-1:0] grown_by(
        input logic [decoder_pkg::LINK_BITS-1:0] count,
        input int inc
    );
        int total;
        total = int'(count) + inc;
        if (total > int'(decoder_pkg::LINK_WEIGHT)) total = int'(decoder_pkg::LINK_WEIGHT);
        return total[decoder_pkg::LINK_BITS-1:0];
    endfunction

    // Cluster parity, masked by the touched flag of the root unit
    function automatic logic [decoder_pkg::PU_COUNT-1:0] model_odd();
        logic [decoder_pkg::PU_COUNT-1:0] odd;
        logic parity;
        odd = '0;
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            parity = 1'b0;
            for (int j = 0; j < decoder_pkg::PU_COUNT; j++) begin
                if (m_root[j] == m_root[i]) parity = parity ^ m_defect[j];
            end
            odd[i] = parity & ~m_touched[address_index(m_root[i])];
        end
        return odd;
    endfunction

    task automatic merge_targets();
        int j;
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            next_root[i] = m_root[i];
            next_touched[i] = m_touched[i];
            for (int d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) begin
                j = neighbor_of(i, d);
                if (m_count[i][d] == decoder_pkg::LINK_WEIGHT) begin
                    if (at_boundary(i, d)) begin
                        next_touched[i] = 1'b1;
                    end else if (j >= 0) begin
                        if (m_root[j] < next_root[i]) next_root[i] = m_root[j];
                        next_touched[i] = next_touched[i] | m_touched[j];
                    end
                end
            end
        end
    endtask

    task automatic grow_model(input logic [decoder_pkg::PU_COUNT-1:0] odd);
        int j;
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            for (int d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) begin
                j = neighbor_of(i, d);
                if (at_boundary(i, d)) begin
                    m_count[i][d] = grown_by(m_count[i][d], int'(odd[i])); // Owner only
                end else if (j >= 0) begin
                    m_count[i][d] = grown_by(m_count[i][d], int'(odd[i]) + int'(odd[j]));
                end
            end
        end
    endtask

    // Ascending order reads the round above before it is overwritten
    task automatic load_model(input logic clear_defects);
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            if (clear_defects) begin
                m_defect[i] = 1'b0;
            end else if (i >= decoder_pkg::PU_COUNT - decoder_pkg::PU_COUNT_PER_ROUND) begin
                m_defect[i] =
                    measurements_i[i - (decoder_pkg::PU_COUNT - decoder_pkg::PU_COUNT_PER_ROUND)];
            end else begin
                m_defect[i] = m_defect[i + decoder_pkg::PU_COUNT_PER_ROUND];
            end
            m_root[i] = own_address(i);
            m_touched[i] = 1'b0;
            for (int d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) m_count[i][d] = '0;
        end
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_model(1'b1);
        end else begin
            odd_now = model_odd();
            case (global_stage_i)
                decoder_pkg::STAGE_LOADING: load_model(1'b0);
                decoder_pkg::STAGE_GROW: grow_model(odd_now);
                decoder_pkg::STAGE_MERGE: begin
                    merge_targets();
                    for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
                        m_root[i] = next_root[i];
                        m_touched[i] = next_touched[i];
                    end
                end
                default: ;
            endcase
        end
    end

    task automatic compare_outputs();
        odd_expected = model_odd();
        merge_targets();
        busy_expected = '0;
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            if (global_stage_i == decoder_pkg::STAGE_MERGE
                && (next_root[i] != m_root[i] || next_touched[i] != m_touched[i])) begin
                busy_expected[i] = 1'b1;
            end
            checks++;
            if (roots_i[i] !== m_root[i]) begin
                errors++;
                $display("error: roots_o[%0d] is %h, expected %h", i, roots_i[i], m_root[i]);
            end
        end
        checks += 2;
        if (odd_clusters_i !== odd_expected) begin
            errors++;
            $display("error: odd_clusters_o is %h, expected %h", odd_clusters_i, odd_expected);
        end
        if (busy_i !== busy_expected) begin
            errors++;
            $display("error: busy_o is %h, expected %h", busy_i, busy_expected);
        end
    endtask

    // Outputs are settled halfway through the cycle
    always @(negedge clk_i) begin
        if (rst_n_i) compare_outputs();
    end

    assign error_count_o = errors;
    assign check_count_o = checks;

endmodule

//--- hdl/decoding_graph.sv
module decoding_graph (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic [decoder_pkg::PU_COUNT_PER_ROUND-1:0]           measurements_i,
    input  decoder_pkg::stage_t                                  global_stage_i,
    output logic [decoder_pkg::PU_COUNT-1:0]                     odd_clusters_o,
    output decoder_pkg::pu_address_t [decoder_pkg::PU_COUNT-1:0] roots_o,
    output logic [decoder_pkg::PU_COUNT-1:0]                     busy_o
);

    logic [decoder_pkg::PU_COUNT-1:0] defects;
    logic [decoder_pkg::PU_COUNT-1:0] touched;
    logic [decoder_pkg::PU_COUNT-1:0] measurement_in;
    logic [decoder_pkg::PU_COUNT-1:0] measurement_out;
    decoder_pkg::neighbor_data_t [decoder_pkg::PU_COUNT-1:0] unit_data;

    // One vector per axis, bit i is the link from unit i to its higher neighbor
    logic [decoder_pkg::PU_COUNT-1:0] link_grown [decoder_pkg::NEIGHBOR_COUNT / 2];

    for (genvar i = 0; i < decoder_pkg::PU_COUNT; i++) begin : g_unit
        decoder_pkg::neighbor_data_t [decoder_pkg::NEIGHBOR_COUNT-1:0] data_in;
        logic [decoder_pkg::NEIGHBOR_COUNT-1:0] grown_in;

        // New words enter the top round, older ones shift down
        if (i >= decoder_pkg::PU_COUNT - decoder_pkg::PU_COUNT_PER_ROUND) begin : g_top
            assign measurement_in[i] =
                measurements_i[i - (decoder_pkg::PU_COUNT - decoder_pkg::PU_COUNT_PER_ROUND)];
        end else begin : g_lower
            assign measurement_in[i] = measurement_out[i + decoder_pkg::PU_COUNT_PER_ROUND];
        end

        for (genvar d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) begin : g_dir
            if (decoder_pkg::neighbor_index(i, d) >= 0) begin : g_present
                assign data_in[d] = unit_data[decoder_pkg::neighbor_index(i, d)];
                // Even directions look down the index, so the link sits at the neighbor
                assign grown_in[d] =
                    link_grown[d / 2][(d % 2 == 0) ? decoder_pkg::neighbor_index(i, d) : i];
            end else begin : g_absent
                assign data_in[d] = '0;
                assign grown_in[d] = 1'b0;
            end
        end

        processing_unit #(
            .ADDRESS       (decoder_pkg::index_address(i)),
            .BOUNDARY_MASK (decoder_pkg::boundary_mask(i))
        ) u_unit (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .global_stage_i   (global_stage_i),
            .measurement_i    (measurement_in[i]),
            .odd_i            (odd_clusters_o[i]),
            .neighbor_data_i  (data_in),
            .neighbor_grown_i (grown_in),
            .measurement_o    (measurement_out[i]),
            .data_o           (unit_data[i]),
            .defect_o         (defects[i]),
            .busy_o           (busy_o[i])
        );

        assign roots_o[i] = unit_data[i].root;
        assign touched[i] = unit_data[i].touched;
    end

    // South, east and up are 1, 3 and 5
    for (genvar a = 0; a < decoder_pkg::NEIGHBOR_COUNT / 2; a++) begin : g_axis
        for (genvar i = 0; i < decoder_pkg::PU_COUNT; i++) begin : g_edge
            if (decoder_pkg::neighbor_index(i, 2 * a + 1) >= 0) begin : g_link
                neighbor_link u_link (
                    .clk_i          (clk_i),
                    .rst_n_i        (rst_n_i),
                    .global_stage_i (global_stage_i),
                    .a_odd_i        (odd_clusters_o[i]),
                    .b_odd_i        (odd_clusters_o[decoder_pkg::neighbor_index(i, 2 * a + 1)]),
                    .fully_grown_o  (link_grown[a][i])
                );
            end else begin : g_no_link
                assign link_grown[a][i] = 1'b0; // Grid edge or boundary
            end
        end
    end

    cluster_parity u_parity (
        .defects_i (defects),
        .roots_i   (roots_o),
        .touched_i (touched),
        .odd_o     (odd_clusters_o)
    );

endmodule

//--- hdl/cluster_parity.sv
module cluster_parity (
    input  logic [decoder_pkg::PU_COUNT-1:0]                     defects_i,
    input  decoder_pkg::pu_address_t [decoder_pkg::PU_COUNT-1:0] roots_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                     touched_i,
    output logic [decoder_pkg::PU_COUNT-1:0]                     odd_o
);

    logic [decoder_pkg::PU_COUNT-1:0] root_parity; // Defect parity of the cluster rooted here

    always_comb begin
        root_parity = '0;
        for (int r = 0; r < decoder_pkg::PU_COUNT; r++) begin
            for (int m = 0; m < decoder_pkg::PU_COUNT; m++) begin
                if (roots_i[m] == decoder_pkg::index_address(r)) begin
                    root_parity[r] = root_parity[r] ^ defects_i[m];
                end
            end
        end
    end

    // Each unit takes the flag of its own root
    always_comb begin
        odd_o = '0;
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            for (int r = 0; r < decoder_pkg::PU_COUNT; r++) begin
                if (roots_i[i] == decoder_pkg::index_address(r)) begin
                    odd_o[i] = root_parity[r] & ~touched_i[r]; // Boundary absorbs parity
                end
            end
        end
    end

endmodule

//--- hdl/neighbor_link.sv
module neighbor_link (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  decoder_pkg::stage_t global_stage_i,
    input  logic                a_odd_i,
    input  logic                b_odd_i,
    output logic                fully_grown_o
);

    logic [decoder_pkg::LINK_BITS-1:0] count_q;
    logic [1:0] increment; // Odd endpoints this edge

    // Both ends grow into the same edge
    assign increment = {1'b0, a_odd_i} + {1'b0, b_odd_i};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_LOADING: begin
                    count_q <= '0; // New syndrome, start over
                end
                decoder_pkg::STAGE_GROW: begin
                    count_q <= decoder_pkg::grow_count(count_q, increment);
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    assign fully_grown_o = (count_q == decoder_pkg::LINK_WEIGHT);

endmodule

//--- hdl/processing_unit.sv
module processing_unit #(
    parameter decoder_pkg::pu_address_t ADDRESS = '0,
    parameter logic [decoder_pkg::NEIGHBOR_COUNT-1:0] BOUNDARY_MASK = '0
) (
    input  logic                                                       clk_i,
    input  logic                                                       rst_n_i,
    input  decoder_pkg::stage_t                                        global_stage_i,
    input  logic                                                       measurement_i,
    input  logic                                                       odd_i,
    input  decoder_pkg::neighbor_data_t [decoder_pkg::NEIGHBOR_COUNT-1:0] neighbor_data_i,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0]                     neighbor_grown_i,
    output logic                                                       measurement_o,
    output decoder_pkg::neighbor_data_t                                data_o,
    output logic                                                       defect_o,
    output logic                                                       busy_o
);

    logic defect_q;
    decoder_pkg::pu_address_t root_q;
    logic touched_q;

    decoder_pkg::pu_address_t root_next;
    logic touched_next;
    logic [decoder_pkg::NEIGHBOR_COUNT-1:0] boundary_grown; // Boundary links fully spanned

    // One growth counter per boundary direction, none elsewhere
    for (genvar d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) begin : g_boundary
        if (BOUNDARY_MASK[d]) begin : g_counter
            logic [decoder_pkg::LINK_BITS-1:0] count_q;

            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    count_q <= '0;
                end else if (global_stage_i == decoder_pkg::STAGE_LOADING) begin
                    count_q <= '0;
                end else if (global_stage_i == decoder_pkg::STAGE_GROW) begin
                    count_q <= decoder_pkg::grow_count(count_q, {1'b0, odd_i}); // Owner only
                end
            end

            assign boundary_grown[d] = (count_q == decoder_pkg::LINK_WEIGHT);
        end else begin : g_none
            assign boundary_grown[d] = 1'b0;
        end
    end

    // Smallest root and any touch over the grown links
    always_comb begin
        root_next = root_q;
        touched_next = touched_q | (|boundary_grown);
        for (int d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d++) begin
            if (neighbor_grown_i[d]) begin
                if (neighbor_data_i[d].root < root_next) begin
                    root_next = neighbor_data_i[d].root;
                end
                touched_next = touched_next | neighbor_data_i[d].touched;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            defect_q <= 1'b0;
            root_q <= ADDRESS;
            touched_q <= 1'b0;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_LOADING: begin
                    defect_q <= measurement_i; // Shift one round down
                    root_q <= ADDRESS;
                    touched_q <= 1'b0;
                end
                decoder_pkg::STAGE_MERGE: begin
                    root_q <= root_next;
                    touched_q <= touched_next;
                end
                default: begin
                    root_q <= root_q;
                end
            endcase
        end
    end

    // Still changing, merge not settled
    assign busy_o = (global_stage_i == decoder_pkg::STAGE_MERGE)
        && ((root_next != root_q) || (touched_next != touched_q));

    assign measurement_o = defect_q;  // Feeds the round below
    assign defect_o = defect_q;
    assign data_o = '{root: root_q, touched: touched_q};

endmodule

//--- hdl/decoder_pkg.sv
package decoder_pkg;

    localparam int GRID_X = 3; // Rows
    localparam int GRID_Z = 3; // Columns
    localparam int GRID_U = 2; // Measurement rounds

    localparam int PU_COUNT_PER_ROUND = GRID_X * GRID_Z;
    localparam int PU_COUNT = PU_COUNT_PER_ROUND * GRID_U;

    localparam int X_BITS = 2;
    localparam int Z_BITS = 2;
    localparam int U_BITS = 1;
    localparam int ADDRESS_WIDTH = U_BITS + X_BITS + Z_BITS;

    localparam int LINK_BITS = 2;
    localparam logic [LINK_BITS-1:0] LINK_WEIGHT = 2'd2; // Growth needed to span a link

    localparam int NEIGHBOR_COUNT = 6;

    // Odd directions point toward the higher flat index
    localparam int DIR_NORTH = 0;
    localparam int DIR_SOUTH = 1;
    localparam int DIR_WEST = 2;
    localparam int DIR_EAST = 3;
    localparam int DIR_DOWN = 4;
    localparam int DIR_UP = 5;

    // Round in the MSBs, so the numeric order ranks roots
    typedef struct packed {
        logic [U_BITS-1:0] u;
        logic [X_BITS-1:0] x;
        logic [Z_BITS-1:0] z;
    } pu_address_t;

    typedef enum logic [2:0] {
        STAGE_IDLE = 3'd0,
        STAGE_LOADING = 3'd1,
        STAGE_GROW = 3'd2,
        STAGE_MERGE = 3'd3
    } stage_t;

    typedef struct packed {
        pu_address_t root;
        logic touched; // Cluster reached a boundary
    } neighbor_data_t;

    // Flat index is u * PU_COUNT_PER_ROUND + x * GRID_Z + z
    function automatic pu_address_t index_address(input int index);
        int u;
        int x;
        int z;
        u = index / PU_COUNT_PER_ROUND;
        x = (index % PU_COUNT_PER_ROUND) / GRID_Z;
        z = index % GRID_Z;
        return pu_address_t'(ADDRESS_WIDTH'((u << (X_BITS + Z_BITS)) | (x << Z_BITS) | z));
    endfunction

    // Flat index of the unit across one direction, -1 when there is none
    function automatic int neighbor_index(input int index, input int dir);
        int u;
        int x;
        int z;
        u = index / PU_COUNT_PER_ROUND;
        x = (index % PU_COUNT_PER_ROUND) / GRID_Z;
        z = index % GRID_Z;
        case (dir)
            DIR_NORTH: return (x > 0) ? index - GRID_Z : -1;
            DIR_SOUTH: return (x < GRID_X - 1) ? index + GRID_Z : -1;
            DIR_WEST: return (z > 0) ? index - 1 : -1;
            DIR_EAST: return (z < GRID_Z - 1) ? index + 1 : -1;
            DIR_DOWN: return (u > 0) ? index - PU_COUNT_PER_ROUND : -1;
            DIR_UP: return (u < GRID_U - 1) ? index + PU_COUNT_PER_ROUND : -1;
            default: return -1;
        endcase
    endfunction

    // West and east edges plus the floor below round 0
    function automatic logic [NEIGHBOR_COUNT-1:0] boundary_mask(input int index);
        logic [NEIGHBOR_COUNT-1:0] mask;
        int z;
        mask = '0;
        z = index % GRID_Z;
        mask[DIR_WEST] = (z == 0);
        mask[DIR_EAST] = (z == GRID_Z - 1);
        mask[DIR_DOWN] = (index < PU_COUNT_PER_ROUND);
        return mask;
    endfunction

    // Saturating link growth
    function automatic logic [LINK_BITS-1:0] grow_count(
        input logic [LINK_BITS-1:0] count,
        input logic [1:0] increment
    );
        logic [LINK_BITS:0] sum;
        sum = (LINK_BITS + 1)'(count) + (LINK_BITS + 1)'(increment);
        if (sum >= (LINK_BITS + 1)'(LINK_WEIGHT)) begin
            return LINK_WEIGHT;
        end
        return sum[LINK_BITS-1:0];
    endfunction

endpackage
